// ==== include/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// cache geometry.
`define FETCH_ICACHE_LINES 64
`define FETCH_BLOCK_WORDS  4

// first fetch address out of reset.
`define FETCH_RESET_PC     32'h0000_0100

// set to 1'b0 to silence the design checks.
`define FETCH_ASSERT_ON    1'b1

`endif

// ==== verilog/fetch_pkg.sv ====
`default_nettype none

`include "fetch_cfg.svh"

package fetch_pkg;

    localparam int WORD_SEL_W = $clog2(`FETCH_BLOCK_WORDS);
    localparam int OFFSET_W   = WORD_SEL_W + 2;         // byte offset inside a line.
    localparam int INDEX_W    = $clog2(`FETCH_ICACHE_LINES);
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W;

    typedef logic [31:0]                       addr_t;
    typedef logic [31:0]                       instr_t;
    typedef logic [32*`FETCH_BLOCK_WORDS-1:0]  block_t;   // word 0 in the low bits.
    typedef logic [INDEX_W-1:0]                index_t;
    typedef logic [TAG_W-1:0]                  tag_t;
    typedef logic [WORD_SEL_W-1:0]             word_sel_t;

    typedef enum logic [1:0] {
        ST_LOOKUP,
        ST_MEM_WAIT,
        ST_FILL
    } fetch_state_e;

    function automatic index_t addr_index(input addr_t a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(input addr_t a);
        return a[31 -: TAG_W];
    endfunction

    function automatic word_sel_t addr_word(input addr_t a);
        return a[2 +: WORD_SEL_W];
    endfunction

    function automatic addr_t block_base(input addr_t a);
        return {a[31:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    function automatic instr_t block_word(input block_t b, input word_sel_t s);
        return b[s*32 +: 32];
    endfunction

endpackage

`default_nettype wire

// ==== verilog/fetch_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_pc
    import fetch_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         stall_i,
    input  wire         redirect_i,
    input  wire addr_t  redirect_addr_i,
    input  wire         instr_valid_i,
    input  wire         busy_i,
    output addr_t       pc_o
);

    addr_t pc_q;
    logic  pending_q;
    addr_t pending_addr_q;
    logic  deliver;
    logic  take_now;
    logic  take_pending;

    assign deliver      = instr_valid_i && !stall_i;
    // the delivery from the fill state ends the miss.
    assign take_now     = redirect_i && (!busy_i || deliver);
    assign take_pending = pending_q && (!busy_i || deliver) && !redirect_i;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            pc_q      <= `FETCH_RESET_PC;
            pending_q <= 1'b0;
        end else begin
            if (take_now) begin
                pc_q <= redirect_addr_i;
            end else if (take_pending) begin
                pc_q <= pending_addr_q;            // replaces the advance.
            end else if (deliver) begin
                pc_q <= pc_q + 32'd4;
            end

            if (redirect_i && !take_now) begin
                pending_q <= 1'b1;                 // controller busy, park it.
            end else if (take_now || take_pending) begin
                pending_q <= 1'b0;
            end
        end
    end

    // a newer redirect overwrites an older parked one.
    always_ff @(posedge clk_i) begin
        if (redirect_i && !take_now) begin
            pending_addr_q <= redirect_addr_i;
        end
    end

    assign pc_o = pc_q;

    // redirect targets from the core must be word aligned too.
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_i || !`FETCH_ASSERT_ON)
        pc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== verilog/icache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module icache_array
    import fetch_pkg::*;
(
    input  wire          clk_i,
    input  wire          rst_i,

    input  wire addr_t   lookup_addr_i,
    output logic         hit_o,
    output instr_t       hit_instr_o,

    input  wire          fill_we_i,
    input  wire addr_t   fill_addr_i,
    input  wire block_t  fill_block_i
);

    tag_t                           tag_q  [`FETCH_ICACHE_LINES];
    block_t                         data_q [`FETCH_ICACHE_LINES];
    logic [`FETCH_ICACHE_LINES-1:0] valid_q;

    index_t    rd_index;
    tag_t      rd_tag;
    word_sel_t rd_word;
    index_t    wr_index;

    assign rd_index = addr_index(lookup_addr_i);
    assign rd_tag   = addr_tag(lookup_addr_i);
    assign rd_word  = addr_word(lookup_addr_i);
    assign wr_index = addr_index(fill_addr_i);

    // combinational lookup, same cycle as the address.
    assign hit_o       = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
    assign hit_instr_o = block_word(data_q[rd_index], rd_word);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
        end else if (fill_we_i) begin
            valid_q[wr_index] <= 1'b1;             // hits from the next cycle.
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            tag_q[wr_index]  <= addr_tag(fill_addr_i);
            data_q[wr_index] <= fill_block_i;      // whole line in one write.
        end
    end

    // the controller must hand over a clean line address with each write.
    a_fill_addr_known: assert property (@(posedge clk_i)
        disable iff (!rst_i || !`FETCH_ASSERT_ON)
        fill_we_i |-> !$isunknown(fill_addr_i));

endmodule

`default_nettype wire

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module icache_ctrl
    import fetch_pkg::*;
(
    input  wire          clk_i,
    input  wire          rst_i,
    input  wire          stall_i,
    input  wire addr_t   pc_i,

    // cache array lookup.
    input  wire          hit_i,
    input  wire instr_t  hit_instr_i,

    // main memory block read.
    input  wire          mem_ready_i,
    input  wire          mem_valid_i,
    input  wire block_t  mem_block_i,
    output logic         mem_req_o,
    output addr_t        mem_addr_o,

    // line write into the array.
    output logic         fill_we_o,
    output addr_t        fill_addr_o,
    output block_t       fill_block_o,

    output logic         busy_o,
    output logic         instr_valid_o,
    output instr_t       instr_o,
    output addr_t        instr_addr_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    addr_t        req_addr_q;
    block_t       fill_buf_q;
    logic         captured_q;
    logic         live_q;
    logic         answer;

    assign answer = mem_valid_i || captured_q;    // block in hand this cycle.

    always_comb begin
        state_d       = state_q;
        mem_req_o     = 1'b0;
        fill_we_o     = 1'b0;
        instr_valid_o = 1'b0;
        instr_o       = hit_instr_i;
        instr_addr_o  = pc_i;

        if (!stall_i) begin
            case (state_q)
                ST_LOOKUP: begin
                    if (live_q) begin
                        if (hit_i) begin
                            instr_valid_o = 1'b1;  // hit, word goes out now.
                        end else if (mem_ready_i) begin
                            mem_req_o = 1'b1;
                            state_d   = ST_MEM_WAIT;
                        end
                    end
                end
                ST_MEM_WAIT: begin
                    if (answer) begin
                        fill_we_o = 1'b1;
                        state_d   = ST_FILL;
                    end
                end
                ST_FILL: begin
                    instr_valid_o = 1'b1;
                    instr_o       = block_word(fill_buf_q, addr_word(req_addr_q));
                    instr_addr_o  = req_addr_q;
                    state_d       = ST_LOOKUP;
                end
                default: begin
                    state_d = ST_LOOKUP;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q    <= ST_LOOKUP;
            captured_q <= 1'b0;
            live_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            // an answer seen under stall is kept until the write can go.
            captured_q <= (state_q == ST_MEM_WAIT) && stall_i && answer;
            live_q     <= 1'b1;                    // lookups start after reset.
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_req_o) begin
            req_addr_q <= pc_i;
        end
        if (state_q == ST_MEM_WAIT && mem_valid_i) begin
            fill_buf_q <= mem_block_i;             // memory sends it only once.
        end
    end

    assign mem_addr_o   = block_base(pc_i);
    assign fill_addr_o  = req_addr_q;
    assign fill_block_o = captured_q ? fill_buf_q : mem_block_i;

    // also high on a lookup miss so the pc holds while the request goes out.
    assign busy_o = (state_q != ST_LOOKUP) || !hit_i;

    a_req_from_lookup: assert property (@(posedge clk_i)
        disable iff (!rst_i || !`FETCH_ASSERT_ON)
        mem_req_o |-> (state_q == ST_LOOKUP && mem_ready_i) ##1 (state_q == ST_MEM_WAIT));

    a_fill_from_wait: assert property (@(posedge clk_i)
        disable iff (!rst_i || !`FETCH_ASSERT_ON)
        fill_we_o |-> (state_q == ST_MEM_WAIT) ##1 (state_q == ST_FILL));

    a_no_valid_in_stall: assert property (@(posedge clk_i)
        disable iff (!rst_i || !`FETCH_ASSERT_ON)
        !(instr_valid_o && stall_i));

endmodule

`default_nettype wire

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_top (
    input  wire                              clk_i,
    input  wire                              rst_i,

    // core side.
    input  wire                              stall_i,
    input  wire                              redirect_i,
    input  wire [31:0]                       redirect_addr_i,
    output wire                              instr_valid_o,
    output wire [31:0]                       instr_o,
    output wire [31:0]                       instr_addr_o,

    // main memory controller.
    input  wire                              mem_ready_i,
    input  wire                              mem_valid_i,
    input  wire [32*`FETCH_BLOCK_WORDS-1:0]  mem_block_i,
    output wire                              mem_req_o,
    output wire [31:0]                       mem_addr_o
);

    wire [31:0]                      pc;
    wire                             hit;
    wire [31:0]                      hit_instr;
    wire                             fill_we;
    wire [31:0]                      fill_addr;
    wire [32*`FETCH_BLOCK_WORDS-1:0] fill_block;
    wire                             busy;

    fetch_pc u_pc (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stall_i         (stall_i),
        .redirect_i      (redirect_i),
        .redirect_addr_i (redirect_addr_i),
        .instr_valid_i   (instr_valid_o),       // advance on each delivery.
        .busy_i          (busy),
        .pc_o            (pc)
    );

    icache_array u_array (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_addr_i (pc),
        .hit_o         (hit),
        .hit_instr_o   (hit_instr),
        .fill_we_i     (fill_we),
        .fill_addr_i   (fill_addr),
        .fill_block_i  (fill_block)
    );

    icache_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .pc_i          (pc),
        .hit_i         (hit),
        .hit_instr_i   (hit_instr),
        .mem_ready_i   (mem_ready_i),
        .mem_valid_i   (mem_valid_i),
        .mem_block_i   (mem_block_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .fill_we_o     (fill_we),
        .fill_addr_o   (fill_addr),
        .fill_block_o  (fill_block),
        .busy_o        (busy),
        .instr_valid_o (instr_valid_o),
        .instr_o       (instr_o),
        .instr_addr_o  (instr_addr_o)
    );

endmodule

`default_nettype wire

// ==== verif/refill_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module refill_mem_model (
    input  wire                              clk_i,
    input  wire                              rst_i,
    input  wire                              req_i,
    input  wire [31:0]                       addr_i,
    input  wire [3:0]                        latency_i,   // cycles from request to answer.
    output logic                             ready_o,
    output logic                             valid_o,
    output logic [32*`FETCH_BLOCK_WORDS-1:0] block_o
);

    logic        busy;
    logic [3:0]  cnt;
    logic [31:0] addr_q;
    logic        req_seen;
    logic        rst_seen;
    logic [3:0]  lat_seen;
    logic [31:0] addr_seen;

    // each word holds its own byte address xor a fixed pattern.
    function automatic logic [32*`FETCH_BLOCK_WORDS-1:0] make_block(input logic [31:0] base);
        logic [32*`FETCH_BLOCK_WORDS-1:0] b;
        b = '0;
        for (int w = 0; w < `FETCH_BLOCK_WORDS; w++) begin
            b[w*32 +: 32] = (base + 32'(4 * w)) ^ 32'hA5A5_0000;
        end
        return b;
    endfunction

    initial begin
        busy    = 1'b0;
        cnt     = 4'd0;
        addr_q  = 32'd0;
        ready_o = 1'b1;
        valid_o = 1'b0;
        block_o = '0;
        forever begin
            @(posedge clk_i);
            rst_seen  = rst_i;                    // sample at the edge.
            req_seen  = req_i;
            lat_seen  = latency_i;
            addr_seen = addr_i;
            #1;
            valid_o = 1'b0;
            if (!rst_seen) begin
                busy = 1'b0;
            end else if (busy) begin
                if (cnt <= 4'd1) begin
                    valid_o = 1'b1;               // one pulse, never repeated.
                    block_o = make_block(addr_q);
                    busy    = 1'b0;
                end else begin
                    cnt = cnt - 4'd1;
                end
            end else if (req_seen) begin
                busy   = 1'b1;
                cnt    = lat_seen;
                addr_q = addr_seen;
            end
            ready_o = !busy;
        end
    end

endmodule

`default_nettype wire

// ==== verif/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb;

    localparam int TIMEOUT_CYCLES = 4000;   // worst case with 8-cycle misses, doubled.
    localparam logic [31:0] RST_PC = `FETCH_RESET_PC;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_addr;
    logic [3:0]  mem_latency;
    wire         instr_valid;
    wire [31:0]  instr;
    wire [31:0]  instr_addr;
    wire         mem_ready;
    wire         mem_valid;
    wire [32*`FETCH_BLOCK_WORDS-1:0] mem_block;
    wire         mem_req;
    wire [31:0]  mem_addr;

    logic [31:0] rec_addr[$];
    logic [31:0] rec_data[$];
    int          rec_cycle[$];
    logic [31:0] req_addr[$];
    int          cycle_count;
    int          stall_wait_cycles;
    int          err_count;
    int          pass_tests;
    int          fail_tests;
    logic [31:0] lat_state;
    logic [31:0] stall_state;

    fetch_top uut (
        .clk_i           (clk),
        .rst_i           (rst),
        .stall_i         (stall),
        .redirect_i      (redirect),
        .redirect_addr_i (redirect_addr),
        .instr_valid_o   (instr_valid),
        .instr_o         (instr),
        .instr_addr_o    (instr_addr),
        .mem_ready_i     (mem_ready),
        .mem_valid_i     (mem_valid),
        .mem_block_i     (mem_block),
        .mem_req_o       (mem_req),
        .mem_addr_o      (mem_addr)
    );

    refill_mem_model u_mem (
        .clk_i     (clk),
        .rst_i     (rst),
        .req_i     (mem_req),
        .addr_i    (mem_addr),
        .latency_i (mem_latency),
        .ready_o   (mem_ready),
        .valid_o   (mem_valid),
        .block_o   (mem_block)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return a ^ 32'hA5A5_0000;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0d ns: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic wait_count(input int n);
        while (rec_addr.size() < n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one cycle redirect pulse while the 'last' instruction is being delivered.
    task automatic redirect_after(input int last, input logic [31:0] target);
        wait_count(last - 1);
        redirect      = 1'b1;
        redirect_addr = target;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        wait_count(last);
    endtask

    // needs stall high and a hitting pc on entry; leaves stall high.
    task automatic fetch_single(input logic [31:0] target);
        int n;
        n             = rec_addr.size();
        redirect      = 1'b1;
        redirect_addr = target;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        stall    = 1'b0;
        wait_count(n + 1);
        stall = 1'b1;
    endtask

    task automatic check_run(input int base, input int n, input logic [31:0] start);
        for (int i = 0; i < n; i++) begin
            check_equal("instr_addr_o", rec_addr[base + i], start + 32'(4 * i));
            check_equal("instr_o", rec_data[base + i], expected_word(start + 32'(4 * i)));
        end
    endtask

    task automatic test_reset_cold_miss;
        int e0;
        e0 = err_count;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;
        wait_count(1);
        check_run(0, 1, RST_PC);
        check_equal("request count", req_addr.size(), 1);
        check_equal("request address", req_addr[0], RST_PC & ~32'hF);
        finish_test("reset and cold miss", e0);
    endtask

    task automatic test_sequential;
        int          e0;
        int          blocks;
        logic [31:0] a;
        e0     = err_count;
        blocks = 0;
        redirect_after(40, RST_PC);
        check_run(0, 40, RST_PC);
        for (int i = 0; i < 40; i++) begin
            a = RST_PC + 32'(4 * i);
            if (i == 0 || a[3:0] == 4'd0) begin
                blocks++;                          // a new 16-byte block.
            end
        end
        check_equal("request count", req_addr.size(), blocks);
        finish_test("sequential fetch", e0);
    endtask

    task automatic test_loop_hits;
        int e0;
        e0 = err_count;
        redirect_after(80, 32'h0000_0200);
        check_run(40, 40, RST_PC);
        for (int i = 0; i < 40; i++) begin
            check_equal("hit cycle", rec_cycle[40 + i], rec_cycle[39] + 1 + i);
        end
        check_equal("request count", req_addr.size(), 10);
        finish_test("loop re-fetch hits", e0);
    endtask

    task automatic test_stall;
        int   e0;
        int   r0;
        logic mem_wait;
        e0       = err_count;
        r0       = req_addr.size();
        mem_wait = 1'b0;
        while (rec_addr.size() < 104) begin
            stall_state = xorshift32(stall_state);
            // random stall, plus a few forced ones inside a refill wait.
            stall = (stall_state[1:0] == 2'd0) || (mem_wait && stall_wait_cycles < 3);
            @(posedge clk);
            mem_wait = !mem_ready;                 // refill still outstanding at the edge.
            #1;
        end
        stall = 1'b1;
        check_run(80, 24, 32'h0000_0200);
        check_equal("request count", req_addr.size() - r0, 6);
        check_equal("stall during refill seen", {31'b0, stall_wait_cycles > 0}, 32'd1);
        finish_test("stall", e0);
    endtask

    task automatic test_redirect_in_miss;
        int e0;
        int r0;
        e0    = err_count;
        r0    = req_addr.size();
        stall = 1'b0;
        while (req_addr.size() == r0) begin
            @(posedge clk);
            #1;
        end
        redirect      = 1'b1;                      // refill now outstanding.
        redirect_addr = 32'h0000_0300;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        wait_count(106);
        stall = 1'b1;
        check_run(104, 1, 32'h0000_0260);
        check_run(105, 1, 32'h0000_0300);
        check_equal("request count", req_addr.size() - r0, 2);
        check_equal("miss request", req_addr[r0], 32'h0000_0260);
        check_equal("target request", req_addr[r0 + 1], 32'h0000_0300);
        finish_test("redirect during miss", e0);
    endtask

    task automatic test_conflict;
        int e0;
        int r0;
        e0 = err_count;
        r0 = req_addr.size();
        fetch_single(32'h0000_0800);
        fetch_single(32'h0000_0C00);               // same index, other tag.
        fetch_single(32'h0000_0800);
        check_run(106, 1, 32'h0000_0800);
        check_run(107, 1, 32'h0000_0C00);
        check_run(108, 1, 32'h0000_0800);
        check_equal("request count", req_addr.size() - r0, 3);
        finish_test("conflict eviction", e0);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory latency, 1 to 8 cycles.
    always begin
        @(posedge clk);
        #1;
        lat_state   = xorshift32(lat_state);
        mem_latency = {1'b0, lat_state[2:0]} + 4'd1;
    end

    // monitor: records deliveries and requests.
    always begin
        @(posedge clk);
        if (!rst) begin
            check_equal("instr_valid_o in reset", {31'b0, instr_valid}, 32'd0);
            check_equal("mem_req_o in reset", {31'b0, mem_req}, 32'd0);
        end else begin
            if (instr_valid) begin
                rec_addr.push_back(instr_addr);
                rec_data.push_back(instr);
                rec_cycle.push_back(cycle_count);
                check_equal("instr_valid_o under stall", {31'b0, stall}, 32'd0);
            end
            if (mem_req) begin
                req_addr.push_back(mem_addr);
                check_equal("mem_addr_o alignment", {28'b0, mem_addr[3:0]}, 32'd0);
            end
            if (stall && !mem_ready) begin
                stall_wait_cycles++;
            end
        end
        cycle_count++;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the fetch unit stopped making progress after %0d cycles",
                 TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst               = 1'b0;
        stall             = 1'b0;
        redirect          = 1'b0;
        redirect_addr     = 32'd0;
        mem_latency       = 4'd1;
        lat_state         = 32'h508f;
        stall_state       = xorshift32(32'h508f);
        cycle_count       = 0;
        stall_wait_cycles = 0;
        err_count         = 0;
        pass_tests        = 0;
        fail_tests        = 0;

        test_reset_cold_miss();
        test_sequential();
        test_loop_hits();
        test_stall();
        test_redirect_in_miss();
        test_conflict();

        $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_pc.sv
verilog/icache_array.sv
verilog/icache_ctrl.sv
verilog/fetch_top.sv
verif/refill_mem_model.sv
verif/fetch_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch unit testbench.

VERILATOR ?= verilator
TOP       ?= fetch_tb
SIM_ARGS  ?=
VFLAGS    ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP SIM_ARGS VFLAGS OBJ_DIR FILELIST"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
